// File: rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [6:0] opcode_t;

  // major opcodes still handled by the core
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // alu selectors, shared by the immediate and register forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // alt selects sub and the arithmetic right shift
  localparam logic [6:0] funct7_base = 7'b000_0000;
  localparam logic [6:0] funct7_alt  = 7'b010_0000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } insn_i_t;

  // branch offset bits are scattered around the register fields
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_t     opcode;
  } insn_u_t;

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_b_t b;
    insn_u_t u;
  } insn_t;

endpackage

// File: core_pkg.sv
package core_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  localparam word_t reset_pc = '0;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui just forwards the immediate
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       reg_we;
    logic       is_branch;
    logic [2:0] branch_funct3;
    logic       halt;
  } ctrl_t;

  // one register write per cycle, also the trace seen by the testbench
  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

// File: rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_isa_pkg::insn_t insn,
  output core_pkg::ctrl_t   ctrl,
  output core_pkg::word_t   imm
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  always_comb begin
    ctrl = '0;
    ctrl.rd = insn.r.rd;
    ctrl.rs1 = insn.r.rs1;
    ctrl.rs2 = insn.r.rs2;
    ctrl.alu_op = alu_add;
    ctrl.branch_funct3 = insn.r.funct3;
    imm = '0;

    case (insn.r.opcode)
      op_lui: begin
        imm = {insn.u.imm, 12'b0};
        ctrl.alu_op = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we = 1'b1;
      end
      op_reg_imm: begin
        imm = {{20{insn.i.imm[11]}}, insn.i.imm};
        ctrl.use_imm = 1'b1;
        ctrl.reg_we = 1'b1;
        case (insn.i.funct3)
          f3_add_sub: ctrl.alu_op = alu_add;
          f3_slt:     ctrl.alu_op = alu_slt;
          f3_sltu:    ctrl.alu_op = alu_sltu;
          f3_xor:     ctrl.alu_op = alu_xor;
          f3_or:      ctrl.alu_op = alu_or;
          f3_and:     ctrl.alu_op = alu_and;
          // shift immediates keep a funct7 in the upper imm bits
          f3_sll: begin
            ctrl.alu_op = alu_sll;
            ctrl.reg_we = (insn.r.funct7 == funct7_base);
          end
          default: begin
            ctrl.alu_op = (insn.r.funct7 == funct7_alt) ? alu_sra : alu_srl;
            ctrl.reg_we = (insn.r.funct7 == funct7_base) || (insn.r.funct7 == funct7_alt);
          end
        endcase
      end
      op_reg_reg: begin
        if (insn.r.funct7 == funct7_base) begin
          ctrl.reg_we = 1'b1;
          case (insn.r.funct3)
            f3_add_sub: ctrl.alu_op = alu_add;
            f3_sll:     ctrl.alu_op = alu_sll;
            f3_slt:     ctrl.alu_op = alu_slt;
            f3_sltu:    ctrl.alu_op = alu_sltu;
            f3_xor:     ctrl.alu_op = alu_xor;
            f3_srl_sra: ctrl.alu_op = alu_srl;
            f3_or:      ctrl.alu_op = alu_or;
            default:    ctrl.alu_op = alu_and;
          endcase
        end else if (insn.r.funct7 == funct7_alt) begin
          // only sub and sra exist with the alt funct7
          if (insn.r.funct3 == f3_add_sub) begin
            ctrl.alu_op = alu_sub;
            ctrl.reg_we = 1'b1;
          end else if (insn.r.funct3 == f3_srl_sra) begin
            ctrl.alu_op = alu_sra;
            ctrl.reg_we = 1'b1;
          end
        end
      end
      op_branch: begin
        imm = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
               insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
        ctrl.is_branch = (insn.b.funct3 != 3'b010) && (insn.b.funct3 != 3'b011);
      end
      op_environ: begin
        // ecall is the one encoding with every other field zero
        ctrl.halt = (insn.i.imm == 12'd0) && (insn.i.rs1 == 5'd0) &&
                    (insn.i.funct3 == 3'd0) && (insn.i.rd == 5'd0);
      end
      default: begin
        ctrl.reg_we = 1'b0;
      end
    endcase
  end

endmodule

// File: rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  core_pkg::alu_op_t op,
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  output core_pkg::word_t   result
);
  import core_pkg::*;

  logic [4:0] shamt;
  word_t      sum;
  word_t      diff;

  // shifts only look at the low five bits
  assign shamt = b[4:0];
  assign sum = a + b;
  assign diff = a - b;

  always_comb begin
    case (op)
      alu_add: begin
        result = sum;
      end
      alu_sub: begin
        result = diff;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {31'd0, $signed(a) < $signed(b)};
      end
      alu_sltu: begin
        result = {31'd0, a < b};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = $signed(a) >>> shamt;
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::wb_t      wb,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data
);
  import core_pkg::*;

  localparam int num_regs = 32;

  word_t regs [num_regs];

  // reads are combinational within the cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && (wb.rd != 5'd0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 holds zero no matter what the decoder asks to write
  assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

// File: rv_next_pc.sv
`timescale 1ns/1ps

module rv_next_pc (
  input  logic            clk,
  input  logic            rst,
  input  core_pkg::ctrl_t ctrl,
  input  core_pkg::word_t rs1_data,
  input  core_pkg::word_t rs2_data,
  input  core_pkg::word_t imm,
  output core_pkg::word_t pc
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic  cond;
  logic  taken;
  word_t pc_next;

  always_comb begin
    case (ctrl.branch_funct3)
      f3_beq:  cond = (rs1_data == rs2_data);
      f3_bne:  cond = (rs1_data != rs2_data);
      f3_blt:  cond = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: cond = (rs1_data < rs2_data);
      f3_bgeu: cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign taken = ctrl.is_branch && cond;

  always_comb begin
    if (ctrl.halt) begin
      // ecall parks the core on its own address
      pc_next = pc;
    end else if (taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  // branch offsets from the decoder keep fetch word aligned
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic            clk,
  input  logic            rst,
  input  core_pkg::word_t insn,
  output core_pkg::word_t pc,
  output core_pkg::wb_t   wb,
  output logic            halt
);
  import core_pkg::*;

  ctrl_t ctrl;
  word_t imm;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_b;
  word_t result;

  rv_decode u_decode (
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .wb       (wb),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // immediate forms replace the second register operand
  assign alu_b = ctrl.use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (result)
  );

  rv_next_pc u_next_pc (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc       (pc)
  );

  assign wb.we = ctrl.reg_we;
  assign wb.rd = ctrl.rd;
  assign wb.data = result;
  assign halt = ctrl.halt;

endmodule

// File: tb_core.sv
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  localparam int max_entries = 64;
  // insn, pc, we, rd, data, halt
  localparam int fields = 6;
  localparam word_t nop = 32'h0000_0013;

  logic  clk;
  logic  rst;
  word_t insn;
  word_t pc;
  wb_t   wb;
  logic  halt;

  logic [31:0] table_mem [max_entries*fields];
  int num_entries;
  int cycle_limit;
  int cycles;
  int errors;
  int entries_ok;
  int entries_bad;

  rv_core dut0 (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .pc   (pc),
    .wb   (wb),
    .halt (halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // marks slots the data file never filled
  function automatic logic [31:0] fill_word(input int addr);
    return 32'hbad0_0000 ^ addr;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
      errors++;
    end
  endtask

  // watchdog, limit covers reset plus one cycle per entry plus margin
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles before all entries were checked", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    int base;
    int errors_before;

    rst = 1'b1;
    insn = nop;
    cycles = 0;
    errors = 0;
    entries_ok = 0;
    entries_bad = 0;

    for (int a = 0; a < max_entries * fields; a++) begin
      table_mem[a] = fill_word(a);
    end
    $readmemh("core_input.txt", table_mem);

    num_entries = 0;
    while (num_entries < max_entries &&
           table_mem[num_entries*fields] != fill_word(num_entries*fields)) begin
      num_entries++;
    end
    cycle_limit = 10 + num_entries + 20;
    if (num_entries == 0) begin
      $display("no entries could be read from core_input.txt");
      errors++;
    end

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    for (int e = 0; e < num_entries; e++) begin
      base = e * fields;
      insn <= table_mem[base];
      // outputs are settled by the falling edge
      @(negedge clk);
      errors_before = errors;
      check_value("pc", table_mem[base+1], pc);
      check_value("wb.we", table_mem[base+2], {31'd0, wb.we});
      if (table_mem[base+2][0]) begin
        check_value("wb.rd", table_mem[base+3], {27'd0, wb.rd});
        check_value("wb.data", table_mem[base+4], wb.data);
      end
      check_value("halt", table_mem[base+5], {31'd0, halt});
      if (errors == errors_before) begin
        entries_ok++;
        $display("entry %0d pc 0x%h insn 0x%h ok", e, pc, table_mem[base]);
      end else begin
        entries_bad++;
        $display("entry %0d pc 0x%h insn 0x%h mismatch", e, pc, table_mem[base]);
      end
      @(posedge clk);
    end

    $display("entries passed %0d failed %0d", entries_ok, entries_bad);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: core_input.txt
// insn pc we rd data halt, all hex, one executed instruction per line
// rd and data are only compared when we is 1
123450b7 00000000 1 01 12345000 0 // lui x1, 0x12345
67808093 00000004 1 01 12345678 0 // addi x1, x1, 0x678
ffb00113 00000008 1 02 fffffffb 0 // addi x2, x0, -5
00300193 0000000c 1 03 00000003 0 // addi x3, x0, 3
80000237 00000010 1 04 80000000 0 // lui x4, 0x80000
002082b3 00000014 1 05 12345673 0 // add x5, x1, x2
40218333 00000018 1 06 00000008 0 // sub x6, x3, x2
403153b3 0000001c 1 07 ffffffff 0 // sra x7, x2, x3
00315433 00000020 1 08 1fffffff 0 // srl x8, x2, x3
003124b3 00000024 1 09 00000001 0 // slt x9, x2, x3
00313533 00000028 1 0a 00000000 0 // sltu x10, x2, x3
0020c5b3 0000002c 1 0b edcba983 0 // xor x11, x1, x2
0030e633 00000030 1 0c 1234567b 0 // or x12, x1, x3
0020f6b3 00000034 1 0d 12345678 0 // and x13, x1, x2
00319733 00000038 1 0e 00000018 0 // sll x14, x3, x3
ffc12793 0000003c 1 0f 00000001 0 // slti x15, x2, -4
fff1b813 00000040 1 10 00000001 0 // sltiu x16, x3, -1
fff0c893 00000044 1 11 edcba987 0 // xori x17, x1, -1
7f006913 00000048 1 12 000007f0 0 // ori x18, x0, 0x7f0
0ff0f993 0000004c 1 13 00000078 0 // andi x19, x1, 0xff
00419a13 00000050 1 14 00000030 0 // slli x20, x3, 4
00425a93 00000054 1 15 08000000 0 // srli x21, x4, 4
40425b13 00000058 1 16 f8000000 0 // srai x22, x4, 4
00008013 0000005c 1 00 12345678 0 // addi x0, x1, 0
00300bb3 00000060 1 17 00000003 0 // add x23, x0, x3
00318463 00000064 0 00 00000000 0 // beq x3, x3, +8 taken
00319463 0000006c 0 00 00000000 0 // bne x3, x3, +8 not taken
00309663 00000070 0 00 00000000 0 // bne x1, x3, +12 taken
00314463 0000007c 0 00 00000000 0 // blt x2, x3, +8 taken
fe21cce3 00000084 0 00 00000000 0 // blt x3, x2, -8 not taken
0021d463 00000088 0 00 00000000 0 // bge x3, x2, +8 taken
00315463 00000090 0 00 00000000 0 // bge x2, x3, +8 not taken
0021e463 00000094 0 00 00000000 0 // bltu x3, x2, +8 taken
00316463 0000009c 0 00 00000000 0 // bltu x2, x3, +8 not taken
00317463 000000a0 0 00 00000000 0 // bgeu x2, x3, +8 taken
0021f463 000000a8 0 00 00000000 0 // bgeu x3, x2, +8 not taken
00308463 000000ac 0 00 00000000 0 // beq x1, x3, +8 not taken
ffffffff 000000b0 0 00 00000000 0 // illegal opcode
023100b3 000000b4 0 00 00000000 0 // mul x1, x2, x3 is illegal here
00008c33 000000b8 1 18 12345678 0 // add x24, x1, x0
00000073 000000bc 0 00 00000000 1 // ecall
00000073 000000bc 0 00 00000000 1 // ecall, pc held

// File: tb.f
rv_isa_pkg.sv
core_pkg.sv
rv_decode.sv
rv_alu.sv
rv_regfile.sv
rv_next_pc.sv
rv_core.sv
tb_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_core -o tb_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
